/* src/CorePkg.sv */
package CorePkg;

    // ---------------------
    // reorder buffer sizing
    // ---------------------
    localparam int robDepth = 8; // power of two, tags wrap naturally.

    // names an in-flight result by its ROB slot.
    typedef logic [2:0] tagT;

    typedef logic [31:0] wordT;

    // occupancy, 0 up to robDepth.
    typedef logic [3:0] robCountT;

endpackage

/* src/IsaPkg.sv */
package IsaPkg;

    // ---------------------
    // instruction fields
    // ---------------------
    typedef logic [31:0] instrT;
    typedef logic [4:0] regNameT;
    typedef logic [6:0] opcodeT;

    localparam opcodeT opOp = 7'b0110011;    // register-register.
    localparam opcodeT opOpImm = 7'b0010011; // register-immediate.

    // ---------------------
    // execution
    // ---------------------
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor
    } aluOpT;

endpackage

/* src/InstrFrontend.sv */
`timescale 1ns/1ps

module InstrFrontend (
    input  logic             clk,
    input  logic             rst,
    input  logic             instrReq,
    input  IsaPkg::instrT    instr,
    output logic             instrAck,
    output logic             allocValid,
    output IsaPkg::regNameT  allocName,
    input  CorePkg::tagT     allocTag,
    input  logic             robFull,
    output CorePkg::tagT     lookTagA,
    output CorePkg::tagT     lookTagB,
    input  logic             lookDoneA,
    input  CorePkg::wordT    lookValA,
    input  logic             lookDoneB,
    input  CorePkg::wordT    lookValB,
    output IsaPkg::regNameT  rdNameA,
    output IsaPkg::regNameT  rdNameB,
    input  CorePkg::wordT    rdValA,
    input  CorePkg::wordT    rdValB,
    input  logic             comValid,
    input  IsaPkg::regNameT  comName,
    input  CorePkg::tagT     comTag,
    input  logic             wbValid,
    input  CorePkg::tagT     wbTag,
    input  CorePkg::wordT    wbResult,
    output logic             uopReq,
    input  logic             uopAck,
    output IsaPkg::aluOpT    uopOp,
    output CorePkg::tagT     uopDst,
    output logic             uopReadyA,
    output CorePkg::tagT     uopTagA,
    output CorePkg::wordT    uopValA,
    output logic             uopReadyB,
    output CorePkg::tagT     uopTagB,
    output CorePkg::wordT    uopValB
);

    IsaPkg::opcodeT  opcode;
    IsaPkg::aluOpT   decOp;
    logic            decValid;
    logic            decImm;
    IsaPkg::regNameT decDst;
    IsaPkg::regNameT decSrcA;
    IsaPkg::regNameT decSrcB;
    CorePkg::wordT   decImmVal;
    logic            srcReadyA;
    logic            srcReadyB;
    CorePkg::wordT   srcValA;
    CorePkg::wordT   srcValB;
    logic            accept;

    logic [31:0]     busy;       // register has a result still in flight.
    CorePkg::tagT    renTag [32];

    // --------------------
    // decode
    // --------------------
    assign opcode = instr[6:0];

    always_comb begin
        decValid = 1'b1;
        decImm = (opcode == IsaPkg::opOpImm);
        case (instr[14:12])
            3'b000: decOp = IsaPkg::aluAdd;
            3'b100: decOp = IsaPkg::aluXor;
            3'b110: decOp = IsaPkg::aluOr;
            3'b111: decOp = IsaPkg::aluAnd;
            default: begin
                decOp = IsaPkg::aluAdd;
                decValid = 1'b0;
            end
        endcase
        if (opcode == IsaPkg::opOp) begin
            if (instr[31:25] == 7'b0100000 && instr[14:12] == 3'b000) begin
                decOp = IsaPkg::aluSub;
            end else if (instr[31:25] != 7'b0000000) begin
                decValid = 1'b0;
            end
        end else if (opcode != IsaPkg::opOpImm) begin
            decValid = 1'b0;
        end
        if (!decValid) begin
            decOp = IsaPkg::aluAdd; // turns into 0 + 0 written to x0.
            decImm = 1'b1;
        end
    end

    assign decDst = decValid ? instr[11:7] : '0;
    assign decSrcA = decValid ? instr[19:15] : '0;
    assign decSrcB = (decValid && !decImm) ? instr[24:20] : '0;
    assign decImmVal = decValid ? {{20{instr[31]}}, instr[31:20]} : '0;

    // --------------------
    // operand sourcing
    // --------------------
    assign rdNameA = decSrcA;
    assign rdNameB = decSrcB;
    assign lookTagA = renTag[decSrcA];
    assign lookTagB = renTag[decSrcB];

    always_comb begin
        srcReadyA = 1'b1;
        srcValA = rdValA;
        if (busy[decSrcA]) begin
            if (lookDoneA) begin
                srcValA = lookValA;
            end else if (wbValid && wbTag == lookTagA) begin
                srcValA = wbResult;
            end else begin
                srcReadyA = 1'b0;
            end
        end
    end

    always_comb begin
        srcReadyB = 1'b1;
        srcValB = decImm ? decImmVal : rdValB;
        if (!decImm && busy[decSrcB]) begin
            if (lookDoneB) begin
                srcValB = lookValB;
            end else if (wbValid && wbTag == lookTagB) begin
                srcValB = wbResult;
            end else begin
                srcReadyB = 1'b0;
            end
        end
    end

    // --------------------
    // handshakes and rename
    // --------------------
    assign accept = instrReq && !instrAck && !uopReq && !robFull;
    assign allocValid = accept;
    assign allocName = decDst;

    always_ff @(posedge clk) begin
        if (rst) begin
            instrAck <= 1'b0;
            uopReq <= 1'b0;
            busy <= '0;
        end else begin
            if (accept) begin
                instrAck <= 1'b1;
            end else if (!instrReq) begin
                instrAck <= 1'b0;
            end
            if (accept) begin
                uopReq <= 1'b1;
            end else if (uopAck) begin
                uopReq <= 1'b0;
            end
            // a newer writer may own the register by now.
            if (comValid && renTag[comName] == comTag) begin
                busy[comName] <= 1'b0;
            end
            if (accept && decDst != '0) begin
                busy[decDst] <= 1'b1; // later than the clear so it wins.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            uopOp <= decOp;
            uopDst <= allocTag;
            uopReadyA <= srcReadyA;
            uopTagA <= lookTagA;
            uopValA <= srcValA;
            uopReadyB <= srcReadyB;
            uopTagB <= lookTagB;
            uopValB <= srcValB;
            if (decDst != '0) begin
                renTag[decDst] <= allocTag;
            end
        end else begin
            if (uopReq && !uopReadyA && wbValid && wbTag == uopTagA) begin
                uopReadyA <= 1'b1;
                uopValA <= wbResult;
            end
            if (uopReq && !uopReadyB && wbValid && wbTag == uopTagB) begin
                uopReadyB <= 1'b1;
                uopValB <= wbResult;
            end
        end
    end

    // a waiting operand names an older entry and not the slot being allocated.
    waitOnNewSlot: assert property (@(posedge clk) disable iff (rst)
        accept |-> (srcReadyA || lookTagA != allocTag)
            && (srcReadyB || lookTagB != allocTag));

endmodule

/* src/IssueQueue.sv */
`timescale 1ns/1ps

module IssueQueue #(
    parameter int iqDepth = 4
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          uopReq,
    output logic          uopAck,
    input  IsaPkg::aluOpT uopOp,
    input  CorePkg::tagT  uopDst,
    input  logic          uopReadyA,
    input  CorePkg::tagT  uopTagA,
    input  CorePkg::wordT uopValA,
    input  logic          uopReadyB,
    input  CorePkg::tagT  uopTagB,
    input  CorePkg::wordT uopValB,
    output logic          exReq,
    input  logic          exAck,
    output IsaPkg::aluOpT exOp,
    output CorePkg::tagT  exDst,
    output CorePkg::wordT exA,
    output CorePkg::wordT exB,
    input  logic          wbValid,
    input  CorePkg::tagT  wbTag,
    input  CorePkg::wordT wbResult
);

    localparam int slotW = (iqDepth > 1) ? $clog2(iqDepth) : 1;
    typedef logic [slotW-1:0] slotT;
    typedef logic [slotW:0] countT;

    logic          valid [iqDepth];
    slotT          age [iqDepth]; // 0 is the oldest entry.
    IsaPkg::aluOpT op [iqDepth];
    CorePkg::tagT  dst [iqDepth];
    logic          rdyA [iqDepth];
    logic          rdyB [iqDepth];
    CorePkg::tagT  tagA [iqDepth];
    CorePkg::tagT  tagB [iqDepth];
    CorePkg::wordT valA [iqDepth];
    CorePkg::wordT valB [iqDepth];

    countT count;
    slotT  freeIdx;
    slotT  pickIdx;
    slotT  issueIdx;
    logic  full;
    logic  pickFound;
    logic  take;
    logic  pick;
    logic  retire;

    always_comb begin
        full = 1'b1;
        freeIdx = '0;
        for (int i = iqDepth - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                full = 1'b0;
                freeIdx = slotT'(i);
            end
        end
        pickFound = 1'b0;
        pickIdx = '0;
        for (int i = 0; i < iqDepth; i++) begin
            if (valid[i] && rdyA[i] && rdyB[i] && (!pickFound || age[i] < age[pickIdx])) begin
                pickFound = 1'b1;
                pickIdx = slotT'(i);
            end
        end
    end

    assign take = uopReq && !uopAck && !full;
    assign pick = !exReq && !exAck && pickFound;
    assign retire = exReq && exAck;

    // --------------------
    // control
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < iqDepth; i++) begin
                valid[i] <= 1'b0;
            end
            count <= '0;
            uopAck <= 1'b0;
            exReq <= 1'b0;
        end else begin
            if (take) begin
                uopAck <= 1'b1;
                valid[freeIdx] <= 1'b1;
            end else if (!uopReq) begin
                uopAck <= 1'b0;
            end
            if (retire) begin
                valid[issueIdx] <= 1'b0;
            end
            count <= count + countT'(take) - countT'(retire);
            if (pick) begin
                exReq <= 1'b1;
            end else if (exAck) begin
                exReq <= 1'b0;
            end
        end
    end

    // --------------------
    // entry payload
    // --------------------
    always_ff @(posedge clk) begin
        for (int i = 0; i < iqDepth; i++) begin
            if (wbValid && !rdyA[i] && tagA[i] == wbTag) begin
                rdyA[i] <= 1'b1;
                valA[i] <= wbResult;
            end
            if (wbValid && !rdyB[i] && tagB[i] == wbTag) begin
                rdyB[i] <= 1'b1;
                valB[i] <= wbResult;
            end
            if (retire && age[i] > age[issueIdx]) begin
                age[i] <= age[i] - 1'b1; // everything younger moves up.
            end
        end
        if (take) begin
            op[freeIdx] <= uopOp;
            dst[freeIdx] <= uopDst;
            tagA[freeIdx] <= uopTagA;
            tagB[freeIdx] <= uopTagB;
            rdyA[freeIdx] <= uopReadyA || (wbValid && wbTag == uopTagA);
            rdyB[freeIdx] <= uopReadyB || (wbValid && wbTag == uopTagB);
            valA[freeIdx] <= uopReadyA ? uopValA : wbResult;
            valB[freeIdx] <= uopReadyB ? uopValB : wbResult;
            age[freeIdx] <= slotT'(count - countT'(retire));
        end
        if (pick) begin
            exOp <= op[pickIdx];
            exDst <= dst[pickIdx];
            exA <= valA[pickIdx];
            exB <= valB[pickIdx];
            issueIdx <= pickIdx;
        end
    end

    takeWhileFull: assert property (@(posedge clk) disable iff (rst)
        take |-> count < countT'(iqDepth));

endmodule

/* src/IntExecUnit.sv */
`timescale 1ns/1ps

module IntExecUnit (
    input  logic          clk,
    input  logic          rst,
    input  logic          exReq,
    output logic          exAck,
    input  IsaPkg::aluOpT exOp,
    input  CorePkg::tagT  exDst,
    input  CorePkg::wordT exA,
    input  CorePkg::wordT exB,
    output logic          wbValid,
    output CorePkg::tagT  wbTag,
    output CorePkg::wordT wbResult
);

    CorePkg::wordT aluOut;
    logic          start;

    assign start = exReq && !exAck;

    always_comb begin
        case (exOp)
            IsaPkg::aluSub: aluOut = exA - exB;
            IsaPkg::aluAnd: aluOut = exA & exB;
            IsaPkg::aluOr:  aluOut = exA | exB;
            IsaPkg::aluXor: aluOut = exA ^ exB;
            default:        aluOut = exA + exB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exAck <= 1'b0;
            wbValid <= 1'b0;
        end else begin
            wbValid <= start; // single cycle, ack blocks a second one.
            if (start) begin
                exAck <= 1'b1;
            end else if (!exReq) begin
                exAck <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            wbTag <= exDst;
            wbResult <= aluOut;
        end
    end

endmodule

/* src/ReorderBuffer.sv */
`timescale 1ns/1ps

module ReorderBuffer (
    input  logic             clk,
    input  logic             rst,
    input  logic             allocValid,
    input  IsaPkg::regNameT  allocName,
    output CorePkg::tagT     allocTag,
    output logic             robFull,
    input  CorePkg::tagT     lookTagA,
    input  CorePkg::tagT     lookTagB,
    output logic             lookDoneA,
    output CorePkg::wordT    lookValA,
    output logic             lookDoneB,
    output CorePkg::wordT    lookValB,
    input  IsaPkg::regNameT  rdNameA,
    input  IsaPkg::regNameT  rdNameB,
    output CorePkg::wordT    rdValA,
    output CorePkg::wordT    rdValB,
    input  logic             wbValid,
    input  CorePkg::tagT     wbTag,
    input  CorePkg::wordT    wbResult,
    output logic             comValid,
    output IsaPkg::regNameT  comName,
    output CorePkg::wordT    comValue,
    output CorePkg::tagT     comTag
);

    IsaPkg::regNameT   name [CorePkg::robDepth];
    logic              done [CorePkg::robDepth];
    CorePkg::wordT     value [CorePkg::robDepth];
    CorePkg::wordT     regFile [32];

    CorePkg::tagT      head;
    CorePkg::tagT      tail;
    CorePkg::robCountT count;

    assign allocTag = tail;
    assign robFull = (count == CorePkg::robCountT'(CorePkg::robDepth));

    // --------------------
    // lookups and reads
    // --------------------
    assign lookDoneA = done[lookTagA];
    assign lookValA = value[lookTagA];
    assign lookDoneB = done[lookTagB];
    assign lookValB = value[lookTagB];

    assign rdValA = (rdNameA == '0) ? '0 : regFile[rdNameA];
    assign rdValB = (rdNameB == '0) ? '0 : regFile[rdNameB];

    // head retires in the cycle it is done.
    assign comValid = (count != '0) && done[head];
    assign comName = name[head];
    assign comValue = value[head];
    assign comTag = head;

    // --------------------
    // state
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            for (int i = 0; i < 32; i++) begin
                regFile[i] <= '0;
            end
        end else begin
            if (allocValid) begin
                tail <= tail + 1'b1;
            end
            if (comValid) begin
                head <= head + 1'b1;
                if (comName != '0) begin
                    regFile[comName] <= comValue;
                end
            end
            count <= count + CorePkg::robCountT'(allocValid) - CorePkg::robCountT'(comValid);
        end
    end

    always_ff @(posedge clk) begin
        if (allocValid) begin
            name[tail] <= allocName;
            done[tail] <= 1'b0;
        end
        if (wbValid) begin
            done[wbTag] <= 1'b1;
            value[wbTag] <= wbResult;
        end
    end

    // the slot must lie between head and tail.
    wbToFreeSlot: assert property (@(posedge clk) disable iff (rst)
        wbValid |-> CorePkg::robCountT'(CorePkg::tagT'(wbTag - head)) < count);

    allocOverflow: assert property (@(posedge clk) disable iff (rst)
        robFull |-> !allocValid);

endmodule

/* src/Core.sv */
`timescale 1ns/1ps

module Core #(
    parameter int iqDepth = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            instrReq,
    input  IsaPkg::instrT   instr,
    output logic            instrAck,
    output logic            comValid,
    output IsaPkg::regNameT comName,
    output CorePkg::wordT   comValue
);

    logic            allocValid;
    IsaPkg::regNameT allocName;
    CorePkg::tagT    allocTag;
    logic            robFull;
    CorePkg::tagT    lookTagA;
    CorePkg::tagT    lookTagB;
    logic            lookDoneA;
    logic            lookDoneB;
    CorePkg::wordT   lookValA;
    CorePkg::wordT   lookValB;
    IsaPkg::regNameT rdNameA;
    IsaPkg::regNameT rdNameB;
    CorePkg::wordT   rdValA;
    CorePkg::wordT   rdValB;
    CorePkg::tagT    comTag;

    // --------------------
    // frontend to queue
    // --------------------
    logic            uopReq;
    logic            uopAck;
    IsaPkg::aluOpT   uopOp;
    CorePkg::tagT    uopDst;
    logic            uopReadyA;
    logic            uopReadyB;
    CorePkg::tagT    uopTagA;
    CorePkg::tagT    uopTagB;
    CorePkg::wordT   uopValA;
    CorePkg::wordT   uopValB;

    // --------------------
    // queue to ALU, writeback
    // --------------------
    logic            exReq;
    logic            exAck;
    IsaPkg::aluOpT   exOp;
    CorePkg::tagT    exDst;
    CorePkg::wordT   exA;
    CorePkg::wordT   exB;
    logic            wbValid;
    CorePkg::tagT    wbTag;
    CorePkg::wordT   wbResult;

    InstrFrontend frontend (
        .clk, .rst, .instrReq, .instr, .instrAck,
        .allocValid, .allocName, .allocTag, .robFull,
        .lookTagA, .lookTagB, .lookDoneA, .lookValA, .lookDoneB, .lookValB,
        .rdNameA, .rdNameB, .rdValA, .rdValB,
        .comValid, .comName, .comTag,
        .wbValid, .wbTag, .wbResult,
        .uopReq, .uopAck, .uopOp, .uopDst,
        .uopReadyA, .uopTagA, .uopValA, .uopReadyB, .uopTagB, .uopValB
    );

    IssueQueue #(
        .iqDepth(iqDepth)
    ) issueQueue (
        .clk, .rst,
        .uopReq, .uopAck, .uopOp, .uopDst,
        .uopReadyA, .uopTagA, .uopValA, .uopReadyB, .uopTagB, .uopValB,
        .exReq, .exAck, .exOp, .exDst, .exA, .exB,
        .wbValid, .wbTag, .wbResult
    );

    IntExecUnit execUnit (
        .clk, .rst,
        .exReq, .exAck, .exOp, .exDst, .exA, .exB,
        .wbValid, .wbTag, .wbResult
    );

    ReorderBuffer rob (
        .clk, .rst,
        .allocValid, .allocName, .allocTag, .robFull,
        .lookTagA, .lookTagB, .lookDoneA, .lookValA, .lookDoneB, .lookValB,
        .rdNameA, .rdNameB, .rdValA, .rdValB,
        .wbValid, .wbTag, .wbResult,
        .comValid, .comName, .comValue, .comTag
    );

endmodule

/* verif/CoreTb.sv */
`timescale 1ns/1ps

module CoreTb;

    localparam int clkPeriod = 40;
    localparam int resetCycles = 8;
    localparam int burstLen = 12;
    localparam int randomLen = 200;
    localparam int cyclesPerInstr = 40; // generous bound for one instruction.

    logic            clk;
    logic            rst;
    logic            instrReq;
    IsaPkg::instrT   instr;
    logic            instrAck;
    logic            comValid;
    IsaPkg::regNameT comName;
    CorePkg::wordT   comValue;

    // stimulus table, one entry per instruction.
    string           tblTest [$];
    IsaPkg::instrT   tblWord [$];
    IsaPkg::regNameT tblName [$];
    CorePkg::wordT   tblValue [$];

    // commits still to come, oldest first.
    string           expTest [$];
    IsaPkg::regNameT expName [$];
    CorePkg::wordT   expValue [$];

    CorePkg::wordT   refRegs [32];
    logic [31:0]     rngState;
    int              errors;
    int              commitCount;
    int              sentCount;
    string           monTest;
    IsaPkg::regNameT monName;
    CorePkg::wordT   monValue;

    Core #(
        .iqDepth(4)
    ) uut (
        .clk, .rst, .instrReq, .instr, .instrAck,
        .comValid, .comName, .comValue
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // --------------------
    // helpers
    // --------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic IsaPkg::instrT encodeR(input logic [6:0] funct7,
            input IsaPkg::regNameT rs2, input IsaPkg::regNameT rs1,
            input logic [2:0] funct3, input IsaPkg::regNameT rd);
        return {funct7, rs2, rs1, funct3, rd, IsaPkg::opOp};
    endfunction

    function automatic IsaPkg::instrT encodeI(input logic [11:0] imm,
            input IsaPkg::regNameT rs1, input logic [2:0] funct3,
            input IsaPkg::regNameT rd, input IsaPkg::opcodeT opcode);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    // opSel: 0 add, 1 sub, 2 and, 3 or, 4 xor.
    function automatic CorePkg::wordT aluRef(input int opSel,
            input CorePkg::wordT a, input CorePkg::wordT b);
        case (opSel)
            1: return a - b;
            2: return a & b;
            3: return a | b;
            4: return a ^ b;
            default: return a + b;
        endcase
    endfunction

    function automatic logic [2:0] funct3Of(input int opSel);
        case (opSel)
            2: return 3'b111;
            3: return 3'b110;
            4: return 3'b100;
            default: return 3'b000;
        endcase
    endfunction

    task automatic checkValue(input string testName, input logic [31:0] expected,
            input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("ERR %s expected %h actual %h", testName, expected, actual);
        end
    endtask

    task automatic addEntry(input string testName, input IsaPkg::instrT word,
            input IsaPkg::regNameT name, input CorePkg::wordT value);
        tblTest.push_back(testName);
        tblWord.push_back(word);
        tblName.push_back(name);
        tblValue.push_back(value);
    endtask

    task automatic pushExpected(input string testName, input IsaPkg::regNameT name,
            input CorePkg::wordT value);
        expTest.push_back(testName);
        expName.push_back(name);
        expValue.push_back(value);
        sentCount++;
    endtask

    task automatic nextGap(output int gap);
        rngState = xorshift32(rngState);
        gap = int'(rngState[1:0]);
    endtask

    // four-phase handshake on the instruction port.
    task automatic sendInstr(input IsaPkg::instrT word, input int gap);
        @(posedge clk);
        repeat (gap) @(posedge clk);
        instrReq <= 1'b1;
        instr <= word;
        @(negedge clk);
        while (!instrAck) @(negedge clk);
        @(posedge clk);
        instrReq <= 1'b0;
        @(negedge clk);
        while (instrAck) @(negedge clk);
    endtask

    task automatic sendModeled(input string testName, input logic isImm, input int opSel,
            input IsaPkg::regNameT rd, input IsaPkg::regNameT rs1,
            input IsaPkg::regNameT rs2, input logic [11:0] imm, input int gap);
        CorePkg::wordT a;
        CorePkg::wordT b;
        CorePkg::wordT result;
        IsaPkg::instrT word;
        a = refRegs[rs1];
        b = isImm ? {{20{imm[11]}}, imm} : refRegs[rs2];
        result = aluRef(opSel, a, b);
        if (isImm) begin
            word = encodeI(imm, rs1, funct3Of(opSel), rd, IsaPkg::opOpImm);
        end else begin
            word = encodeR((opSel == 1) ? 7'b0100000 : 7'b0000000, rs2, rs1,
                funct3Of(opSel), rd);
        end
        pushExpected(testName, rd, result); // x0 still commits the result.
        if (rd != 5'd0) begin
            refRegs[rd] = result;
        end
        sendInstr(word, gap);
    endtask

    task automatic waitDrain();
        while (expName.size() != 0) @(negedge clk);
    endtask

    // --------------------
    // table
    // --------------------
    task automatic buildTable();
        addEntry("chainAddi1", encodeI(12'd5, 5'd0, 3'b000, 5'd1, IsaPkg::opOpImm), 5'd1, 32'h5);
        addEntry("chainAddi2", encodeI(12'hFFD, 5'd0, 3'b000, 5'd2, IsaPkg::opOpImm),
            5'd2, 32'hFFFFFFFD);
        addEntry("chainAdd", encodeR(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, 32'h2);
        addEntry("chainSub", encodeR(7'b0100000, 5'd1, 5'd3, 3'b000, 5'd4), 5'd4, 32'hFFFFFFFD);
        addEntry("chainAndi", encodeI(12'h0F0, 5'd4, 3'b111, 5'd5, IsaPkg::opOpImm),
            5'd5, 32'hF0);
        addEntry("chainOri", encodeI(12'h00F, 5'd5, 3'b110, 5'd6, IsaPkg::opOpImm), 5'd6, 32'hFF);
        addEntry("chainXori", encodeI(12'hFFF, 5'd6, 3'b100, 5'd7, IsaPkg::opOpImm),
            5'd7, 32'hFFFFFF00);
        addEntry("chainAnd", encodeR(7'b0000000, 5'd4, 5'd7, 3'b111, 5'd1), 5'd1, 32'hFFFFFF00);
        addEntry("chainOr", encodeR(7'b0000000, 5'd5, 5'd1, 3'b110, 5'd2), 5'd2, 32'hFFFFFFF0);
        addEntry("chainXor", encodeR(7'b0000000, 5'd6, 5'd2, 3'b100, 5'd3), 5'd3, 32'hFFFFFF0F);
        addEntry("zeroWrite", encodeI(12'd7, 5'd1, 3'b000, 5'd0, IsaPkg::opOpImm),
            5'd0, 32'hFFFFFF07);
        addEntry("zeroRead", encodeR(7'b0000000, 5'd3, 5'd0, 3'b000, 5'd4), 5'd4, 32'hFFFFFF0F);
        addEntry("loadOp", encodeI(12'd0, 5'd1, 3'b010, 5'd5, 7'b0000011), 5'd0, 32'h0);
        addEntry("slliOp", encodeI(12'd2, 5'd1, 3'b001, 5'd6, IsaPkg::opOpImm), 5'd0, 32'h0);
        addEntry("afterUnsup", encodeI(12'd1, 5'd5, 3'b000, 5'd6, IsaPkg::opOpImm), 5'd6, 32'hF1);
        addEntry("mulOp", encodeR(7'b0000001, 5'd2, 5'd1, 3'b000, 5'd7), 5'd0, 32'h0);
        addEntry("afterMul", encodeR(7'b0000000, 5'd6, 5'd7, 3'b100, 5'd7), 5'd7, 32'hFFFFFFF1);
    endtask

    // commits are compared in program order.
    always @(negedge clk) begin
        if (!rst && comValid) begin
            commitCount++;
            if (expName.size() == 0) begin
                errors++;
                $display("a commit of register %0d arrived with no instruction outstanding",
                    comName);
            end else begin
                monTest = expTest.pop_front();
                monName = expName.pop_front();
                monValue = expValue.pop_front();
                checkValue({monTest, " name"}, {27'b0, monName}, {27'b0, comName});
                checkValue({monTest, " value"}, monValue, comValue);
            end
        end
    end

    initial begin
        int limit;
        #1;
        limit = (tblWord.size() + burstLen + randomLen) * cyclesPerInstr + resetCycles;
        #(limit * clkPeriod);
        $display("the run timed out after %0d cycles with %0d commits still missing",
            limit, expName.size());
        $display("Testbench failed");
        $finish;
    end

    // --------------------
    // main sequence
    // --------------------
    initial begin
        int gap;
        int opSel;
        int burstStart;
        logic isImm;
        logic [31:0] draw;
        rst = 1'b1;
        instrReq = 1'b0;
        instr = '0;
        errors = 0;
        commitCount = 0;
        sentCount = 0;
        rngState = 32'd6366;
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = '0;
        end
        buildTable();
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;

        repeat (4) begin
            @(negedge clk);
            checkValue("idleAck", 32'd0, {31'b0, instrAck});
            checkValue("idleCommit", 32'd0, {31'b0, comValid});
        end

        for (int i = 0; i < tblWord.size(); i++) begin
            nextGap(gap);
            pushExpected(tblTest[i], tblName[i], tblValue[i]);
            if (tblName[i] != 5'd0) begin
                refRegs[tblName[i]] = tblValue[i];
            end
            sendInstr(tblWord[i], gap);
        end
        waitDrain();

        // independent ops from x0, sent back to back.
        burstStart = commitCount;
        for (int i = 0; i < burstLen; i++) begin
            opSel = (i % 5 == 1) ? 0 : i % 5;
            sendModeled("burst", 1'b1, opSel, 5'(1 + i % 7), 5'd0, 5'd0, 12'(i * 37 + 1), 0);
        end
        waitDrain();
        checkValue("burstCount", burstLen, commitCount - burstStart);

        for (int i = 0; i < randomLen; i++) begin
            rngState = xorshift32(rngState);
            draw = rngState;
            opSel = int'(draw[31:28]) % 5;
            isImm = draw[22];
            if (isImm && opSel == 1) begin
                opSel = 0; // no subtract immediate.
            end
            nextGap(gap);
            sendModeled($sformatf("random%0d", i), isImm, opSel, {2'b0, draw[14:12]},
                {2'b0, draw[17:15]}, {2'b0, draw[20:18]}, draw[11:0], gap);
        end
        waitDrain();
        checkValue("commitCount", sentCount, commitCount);

        $display("errors: %0d  commits: %0d of %0d", errors, commitCount, sentCount);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* compile.f */
src/CorePkg.sv
src/IsaPkg.sv
src/InstrFrontend.sv
src/IssueQueue.sv
src/IntExecUnit.sv
src/ReorderBuffer.sv
src/Core.sv
verif/CoreTb.sv

/* run.sh */
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module CoreTb -f compile.f -o CoreSim
./obj_dir/CoreSim > sim.log 2>&1
cat sim.log
if grep -q "Testbench failed" sim.log; then
    exit 1
fi
exit 0
